// ==== all.f ====
+incdir+logic
logic/poly_pkg.sv
logic/spi_write_slave.sv
logic/vertex_ram.sv
logic/polyline_ctrl.sv
logic/line_stepper.sv
logic/lcd_pixel_tx.sv
logic/polyline_top.sv
tb/polyline_assert.sv
tb/polyline_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module polyline_tb -f all.f -Mdir obj_dir
	./obj_dir/Vpolyline_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/polyline_tb.sv ====
`include "poly_cfg.svh"

module polyline_tb;
  import poly_pkg::*;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    NUM_TESTS   = 13;
  localparam int    MAX_PIX     = 300;   // 7 segments of up to 41 pixels
  localparam int    CLK_PER_PIX = 13 * 8 * 2 * `LCD_SCK_DIV + 10;
  localparam int    SPI_CLK     = 50 * 8 * 10 * 2;  // generous frame budget per test
  localparam longint TIMEOUT_NS = longint'(NUM_TESTS) * (MAX_PIX * CLK_PER_PIX + SPI_CLK) * 20;

  logic clk;
  logic arst_n;
  logic csn, sclk, mosi;
  logic busy;
  logic lcd_sck, lcd_mosi, lcd_dc, lcd_csn, lcd_resn;

  logic [31:0] rng_state = 32'd67517;
  logic [15:0] vx_q[$];       // polyline under test
  logic [15:0] vy_q[$];
  logic [7:0]  frame_q[$];    // spi payload after the address
  pixel_t      exp_q[$];
  pixel_t      got_q[$];      // appended by the lcd monitor only
  int          got_rd;
  int          errors, checks, err_mark, tests_run, tests_bad;
  int          proto_err, proto_mark;
  string       cur_test = "reset";

  // lcd monitor state
  logic [2:0]  bit_n;
  logic [3:0]  byte_n;
  logic [7:0]  sh;
  logic [7:0]  rx_bytes[13];
  logic        exp_dc;
  logic [7:0]  exp_cmd;
  pixel_t      px_rx;

  polyline_top dut (
    .clk(clk), .arst_n(arst_n), .csn(csn), .sclk(sclk), .mosi(mosi), .busy(busy),
    .lcd_sck(lcd_sck), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc), .lcd_csn(lcd_csn),
    .lcd_resn(lcd_resn)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  // ****************************************
  // lcd byte decoder
  // ****************************************
  always @(posedge lcd_sck or negedge lcd_csn) begin
    if (!lcd_sck) begin  // csn just fell, new pixel
      bit_n  = 3'd0;
      byte_n = 4'd0;
    end else if (!lcd_csn) begin
      sh = {sh[6:0], lcd_mosi};  // msb first
      if (bit_n == 3'd7) begin
        exp_dc  = !(byte_n == 4'd0 || byte_n == 4'd5 || byte_n == 4'd10);
        exp_cmd = (byte_n == 4'd0) ? `LCD_CASET : (byte_n == 4'd5) ? `LCD_RASET : `LCD_RAMWR;
        if (lcd_dc !== exp_dc) begin
          $display("lcd_dc wrong on byte %0d of a pixel in test %s", byte_n, cur_test);
          proto_err++;
        end
        if (!exp_dc && sh !== exp_cmd) begin
          $display("lcd command byte %0d is %h instead of %h in test %s",
                   byte_n, sh, exp_cmd, cur_test);
          proto_err++;
        end
        if (byte_n <= 4'd12) rx_bytes[byte_n] = sh;
        if (byte_n == 4'd12) begin  // colour lsb closes the pixel
          px_rx.x     = {rx_bytes[1], rx_bytes[2]};
          px_rx.y     = {rx_bytes[6], rx_bytes[7]};
          px_rx.color = {rx_bytes[11], rx_bytes[12]};
          if ({rx_bytes[3], rx_bytes[4]} !== px_rx.x || {rx_bytes[8], rx_bytes[9]} !== px_rx.y) begin
            $display("lcd window start and end differ in test %s", cur_test);
            proto_err++;
          end
          got_q.push_back(px_rx);
        end
        byte_n = byte_n + 4'd1;
      end
      bit_n = bit_n + 3'd1;
    end
  end

  // ****************************************
  // helpers
  // ****************************************
  function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];  // upper bits, better period
  endfunction

  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic after_edges(input int n);
    repeat (n) @(posedge clk);
    #2;  // inputs move just after the edge
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      mosi = b[i];
      sclk = 1'b0;
      after_edges(5);
      sclk = 1'b1;  // slave samples here
      after_edges(5);
    end
  endtask

  // one write frame, payload taken from frame_q
  task automatic spi_write(input logic [31:0] addr);
    after_edges(1);  // frame starts just after a rising edge
    csn = 1'b0;
    after_edges(5);
    send_byte(8'h00);
    send_byte(addr[31:24]);
    send_byte(addr[23:16]);
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
    foreach (frame_q[i]) send_byte(frame_q[i]);
    sclk = 1'b0;
    after_edges(5);
    csn = 1'b1;
    after_edges(10);  // let csn sync before next frame
    frame_q.delete();
  endtask

  task automatic write_vertices();
    foreach (vx_q[i]) begin
      frame_q.push_back(vx_q[i][15:8]);
      frame_q.push_back(vx_q[i][7:0]);
      frame_q.push_back(vy_q[i][15:8]);
      frame_q.push_back(vy_q[i][7:0]);
    end
    spi_write({`POLY_BUF_BASE, 16'h0000});
  endtask

  task automatic write_regs(input logic [15:0] col, input logic [15:0] cnt);
    frame_q.push_back(col[15:8]);
    frame_q.push_back(col[7:0]);
    frame_q.push_back(cnt[15:8]);
    frame_q.push_back(cnt[7:0]);  // count lsb kicks off the draw
    spi_write({`POLY_REG_BASE, 16'h0000});
  endtask

  task automatic write_count_lsb(input logic [7:0] cnt);
    frame_q.push_back(cnt);
    spi_write({`POLY_REG_BASE, 16'h0003});
  endtask

  // reference bresenham, both endpoints included
  function automatic void model_line(input logic [15:0] xs, ys, xe, ye, col);
    int     x, y, dx, dy, sx, sy, err, e2;
    bit     done;
    pixel_t p;
    x    = int'(xs);
    y    = int'(ys);
    dx   = (xe >= xs) ? int'(xe) - int'(xs) : int'(xs) - int'(xe);
    dy   = (ye >= ys) ? int'(ys) - int'(ye) : int'(ye) - int'(ys);  // negative magnitude
    sx   = (xe >= xs) ? 1 : -1;
    sy   = (ye >= ys) ? 1 : -1;
    err  = dx + dy;
    done = 1'b0;
    while (!done) begin
      p.x     = 16'(x);
      p.y     = 16'(y);
      p.color = col;
      exp_q.push_back(p);
      if (x == int'(xe) && y == int'(ye)) begin
        done = 1'b1;
      end else begin
        e2 = 2 * err;
        if (e2 >= dy) begin
          err = err + dy;
          x   = x + sx;
        end
        if (e2 <= dx) begin
          err = err + dx;
          y   = y + sy;
        end
      end
    end
  endfunction

  task automatic build_model(input logic [15:0] col, input int cnt);
    for (int s = 0; s + 1 < cnt; s++) begin
      model_line(vx_q[s], vy_q[s], vx_q[s+1], vy_q[s+1], col);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);  // busy settled here
    while (busy && n < MAX_PIX * CLK_PER_PIX) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("busy stayed high too long in test %s", cur_test);
      errors++;
    end
  endtask

  task automatic compare_pixels();
    int got_n;
    got_n = got_q.size() - got_rd;
    check({cur_test, " pixel count"}, 64'(exp_q.size()), 64'(got_n));
    for (int i = 0; i < exp_q.size() && i < got_n; i++) begin
      check($sformatf("%s pixel %0d", cur_test, i), 64'(exp_q[i]), 64'(got_q[got_rd + i]));
    end
    check({cur_test, " lcd protocol"}, 64'(0), 64'(proto_err - proto_mark));
    got_rd     = got_q.size();
    proto_mark = proto_err;
    exp_q.delete();
  endtask

  task automatic draw_current(input logic [15:0] col);
    build_model(col, vx_q.size());
    write_vertices();
    write_regs(col, 16'(vx_q.size()));
    wait_idle();
    compare_pixels();
  endtask

  task automatic set_vertex(input logic [15:0] x, input logic [15:0] y);
    vx_q.push_back(x);
    vy_q.push_back(y);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("%-12s ok", cur_test);
    end else begin
      $display("%-12s fail", cur_test);
      tests_bad++;
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    arst_n = 1'b0;
    csn    = 1'b1;
    sclk   = 1'b0;
    mosi   = 1'b0;
    start_test("reset");
    repeat (10) @(posedge clk);
    #2;
    check("reset lcd_resn low", 64'(0), 64'(lcd_resn));  // display held in reset
    arst_n = 1'b1;
    after_edges(5);

    @(negedge clk);
    check("reset lcd_resn", 64'(1), 64'(lcd_resn));
    check("reset lcd_csn", 64'(1), 64'(lcd_csn));
    check("reset busy", 64'(0), 64'(busy));
    finish_test();

    start_test("directed");  // horizontal, vertical, single point
    set_vertex(16'd10, 16'd20);
    set_vertex(16'd30, 16'd20);
    set_vertex(16'd30, 16'd45);
    set_vertex(16'd30, 16'd45);
    draw_current(16'hF800);
    finish_test();

    for (int t = 0; t < 6; t++) begin
      start_test($sformatf("random%0d", t));
      vx_q.delete();
      vy_q.delete();
      repeat (2 + int'(rand16() % 16'd7)) begin
        set_vertex(16'd200 + rand16() % 16'd40, 16'd10 + rand16() % 16'd40);
      end
      draw_current(rand16());
      finish_test();
    end

    start_test("count0");
    write_regs(16'h07E0, 16'd0);
    wait_idle();
    compare_pixels();  // empty model
    finish_test();

    start_test("count1");
    write_regs(16'h07E0, 16'd1);
    wait_idle();
    compare_pixels();
    finish_test();

    start_test("busy_write");  // long segment keeps busy up during a frame
    vx_q.delete();
    vy_q.delete();
    set_vertex(16'd0, 16'd0);
    set_vertex(16'd35, 16'd7);
    draw_current(16'h001F);
    build_model(16'h001F, 2);
    write_vertices();
    write_regs(16'h001F, 16'd2);
    @(negedge clk);
    check("busy_write busy before frame", 64'(1), 64'(busy));
    write_regs(16'hABCD, 16'd2);  // must not restart
    @(negedge clk);
    check("busy_write busy after frame", 64'(1), 64'(busy));
    wait_idle();
    compare_pixels();
    after_edges(2 * CLK_PER_PIX);  // room for a whole stray pixel
    check("busy_write no second draw", 64'(0), 64'(busy));
    check("busy_write extra pixels", 64'(0), 64'(got_q.size() - got_rd));
    finish_test();

    start_test("new_color");
    build_model(16'hABCD, 2);
    write_count_lsb(8'd2);
    wait_idle();
    compare_pixels();
    finish_test();

    start_test("outside");
    repeat (8) frame_q.push_back(8'(rand16()));
    spi_write(32'h1CDC_0000);  // just below the buffer
    repeat (8) frame_q.push_back(8'(rand16()));
    spi_write(32'h1CDF_0000);  // just above the registers
    repeat (8) frame_q.push_back(8'hFF);
    spi_write(32'h0000_0000);
    after_edges(20);
    check("outside busy after junk", 64'(0), 64'(busy));
    build_model(16'hABCD, 2);
    write_count_lsb(8'd2);
    wait_idle();
    compare_pixels();
    finish_test();

    $display("%0d tests, %0d failing, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb/polyline_assert.sv ====
module polyline_assert (
  input logic              clk,
  input logic              arst_n,
  input logic              busy,
  input logic              lcd_sck,
  input logic              lcd_dc,
  input logic              lcd_csn,
  input poly_pkg::bus_wr_t bus_wr,
  input poly_pkg::pixel_t  px,
  input logic              px_valid,
  input logic              px_take
);
  import poly_pkg::*;

  timeunit 1ns;
  timeprecision 100ps;

  // ****************************************
  // lcd link
  // ****************************************
  dc_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (!lcd_csn && lcd_sck) |-> $stable(lcd_dc))  // dc only moves on falling sck
    else $error("lcd_dc changed while a byte was shifting");

  csn_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !busy |-> lcd_csn)
    else $error("lcd_csn low while busy is low");

  // host side start
  busy_cause: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(bus_wr.valid))
    else $error("busy rose with no bus write before it");

  // stepper hand-off
  px_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (px_valid && !px_take) |=> (px_valid && $stable(px)))
    else $error("pixel dropped or changed before px_take");

endmodule

bind polyline_top polyline_assert u_assert (
  .clk(clk), .arst_n(arst_n), .busy(busy), .lcd_sck(lcd_sck), .lcd_dc(lcd_dc),
  .lcd_csn(lcd_csn), .bus_wr(bus_wr), .px(px), .px_valid(px_valid), .px_take(px_take)
);

// ==== logic/polyline_top.sv ====
module polyline_top (
  input  logic clk,
  input  logic arst_n,
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic busy,
  output logic lcd_sck,
  output logic lcd_mosi,
  output logic lcd_dc,
  output logic lcd_csn,
  output logic lcd_resn
);
  import poly_pkg::*;

  bus_wr_t     bus_wr;       // host byte writes
  logic [9:0]  rd_addr;
  logic [15:0] rd_data;
  logic        line_start;
  logic        line_done;
  vertex_t     seg_from;
  vertex_t     seg_to;
  logic [15:0] color;
  pixel_t      px;
  logic        px_valid;
  logic        px_take;
  logic        lcd_idle;

  // **************************************
  // host side
  // **************************************
  spi_write_slave u_spi (
    .clk(clk), .arst_n(arst_n), .csn(csn), .sclk(sclk), .mosi(mosi), .bus_wr(bus_wr)
  );

  vertex_ram u_ram (
    .clk(clk), .arst_n(arst_n), .bus_wr(bus_wr), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  polyline_ctrl u_ctrl (
    .clk(clk), .arst_n(arst_n), .bus_wr(bus_wr), .rd_addr(rd_addr), .rd_data(rd_data),
    .line_start(line_start), .seg_from(seg_from), .seg_to(seg_to),
    .line_done(line_done), .lcd_idle(lcd_idle), .color(color), .busy(busy)
  );

  // **************************************
  // pixel side
  // **************************************
  line_stepper u_step (
    .clk(clk), .arst_n(arst_n), .line_start(line_start), .seg_from(seg_from),
    .seg_to(seg_to), .color(color), .px(px), .px_valid(px_valid),
    .px_take(px_take), .line_done(line_done)
  );

  lcd_pixel_tx u_tx (
    .clk(clk), .arst_n(arst_n), .px(px), .px_valid(px_valid), .px_take(px_take),
    .lcd_idle(lcd_idle), .lcd_sck(lcd_sck), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc),
    .lcd_csn(lcd_csn), .lcd_resn(lcd_resn)
  );

endmodule

// ==== logic/lcd_pixel_tx.sv ====
`include "poly_cfg.svh"

module lcd_pixel_tx (
  input  logic             clk,
  input  logic             arst_n,
  input  poly_pkg::pixel_t px,
  input  logic             px_valid,
  output logic             px_take,
  output logic             lcd_idle,
  output logic             lcd_sck,
  output logic             lcd_mosi,
  output logic             lcd_dc,
  output logic             lcd_csn,
  output logic             lcd_resn
);
  import poly_pkg::*;

  localparam int unsigned DIV = `LCD_SCK_DIV;

  typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_SHIFT, TX_TAIL} tx_state_t;

  tx_state_t   state;
  pixel_t      pix_q;
  logic [3:0]  slot;     // 0..12 within the window sequence
  logic [2:0]  bit_cnt;
  logic [7:0]  shreg;
  logic [15:0] div_cnt;
  logic        div_done;
  logic [8:0]  nxt_word; // {dc, byte} of the following slot

  // {dc, byte} for each slot of the 13 byte sequence
  function automatic logic [8:0] slot_word(input logic [3:0] s, input pixel_t p);
    case (s)
      4'd0:         return {1'b0, `LCD_CASET};
      4'd1, 4'd3:   return {1'b1, p.x[15:8]};
      4'd2, 4'd4:   return {1'b1, p.x[7:0]};   // start and end column equal
      4'd5:         return {1'b0, `LCD_RASET};
      4'd6, 4'd8:   return {1'b1, p.y[15:8]};
      4'd7, 4'd9:   return {1'b1, p.y[7:0]};
      4'd10:        return {1'b0, `LCD_RAMWR};
      4'd11:        return {1'b1, p.color[15:8]};
      default:      return {1'b1, p.color[7:0]};
    endcase
  endfunction

  assign div_done = (div_cnt == 16'(DIV - 1));
  assign nxt_word = slot_word(slot + 4'd1, pix_q);
  assign lcd_idle = (state == TX_IDLE);
  assign px_take  = lcd_idle & px_valid;
  assign lcd_mosi = shreg[7];

  // **************************************
  // byte sequencer and shifter
  // **************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= TX_IDLE;
      slot    <= '0;
      bit_cnt <= '0;
      shreg   <= '0;
      div_cnt <= '0;
      lcd_sck <= 1'b0;
      lcd_dc  <= 1'b1;
      lcd_csn <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: if (px_take) state <= TX_LOAD;
        TX_LOAD: begin
          {lcd_dc, shreg} <= slot_word(4'd0, pix_q);
          slot    <= '0;
          bit_cnt <= '0;
          div_cnt <= '0;
          lcd_sck <= 1'b0;
          lcd_csn <= 1'b0;
          state   <= TX_SHIFT;
        end
        TX_SHIFT: begin
          if (!div_done) begin
            div_cnt <= div_cnt + 16'd1;
          end else begin
            div_cnt <= '0;
            lcd_sck <= ~lcd_sck;
            if (lcd_sck) begin            // falling edge, move data
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt != 3'd7) begin
                shreg <= {shreg[6:0], 1'b0};
              end else if (slot == 4'd12) begin
                state <= TX_TAIL;         // last bit out
              end else begin
                slot            <= slot + 4'd1;
                {lcd_dc, shreg} <= nxt_word;
              end
            end
          end
        end
        TX_TAIL: begin
          lcd_csn <= 1'b1;
          lcd_dc  <= 1'b1;
          state   <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (px_take) pix_q <= px;  // stepper may move on now
  end

  // display reset released one clk after our reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) lcd_resn <= 1'b0;
    else         lcd_resn <= 1'b1;
  end

endmodule

// ==== logic/line_stepper.sv ====
module line_stepper (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              line_start,
  input  poly_pkg::vertex_t seg_from,
  input  poly_pkg::vertex_t seg_to,
  input  logic [15:0]       color,
  output poly_pkg::pixel_t  px,
  output logic              px_valid,
  input  logic              px_take,
  output logic              line_done
);
  import poly_pkg::*;

  step_state_t        state;
  logic [15:0]        cur_x, cur_y;
  logic [15:0]        end_x, end_y;
  logic signed [16:0] diff_x, diff_y;
  logic signed [16:0] dx;      // |x1 - x0|
  logic signed [16:0] dy;      // -|y1 - y0|
  logic               sx_neg, sy_neg;
  logic signed [17:0] err;
  logic signed [18:0] e2;
  logic signed [17:0] err_nx;
  logic               step_x, step_y;
  logic               at_end;

  assign diff_x = $signed({1'b0, seg_to.x}) - $signed({1'b0, seg_from.x});
  assign diff_y = $signed({1'b0, seg_to.y}) - $signed({1'b0, seg_from.y});

  // **************************************
  // step decision
  // **************************************
  assign e2     = $signed({err, 1'b0});
  assign step_x = (e2 >= dy);
  assign step_y = (e2 <= dx);
  assign at_end = (cur_x == end_x) && (cur_y == end_y);
  assign err_nx = err
                + (step_x ? $signed({dy[16], dy}) : 18'sd0)
                + (step_y ? $signed({dx[16], dx}) : 18'sd0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= STP_IDLE;
      line_done <= 1'b0;
    end else begin
      line_done <= 1'b0;
      case (state)
        STP_IDLE:  if (line_start) state <= STP_SETUP;
        STP_SETUP: state <= STP_EMIT;
        STP_EMIT: begin
          if (px_take && at_end) begin
            state     <= STP_IDLE;  // endpoint handed over
            line_done <= 1'b1;
          end
        end
        default: state <= STP_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state == STP_IDLE && line_start) begin
      cur_x  <= seg_from.x;
      cur_y  <= seg_from.y;
      end_x  <= seg_to.x;
      end_y  <= seg_to.y;
      dx     <= diff_x[16] ? -diff_x : diff_x;
      dy     <= diff_y[16] ? diff_y : -diff_y;
      sx_neg <= diff_x[16];
      sy_neg <= diff_y[16];
    end
    if (state == STP_SETUP) begin
      err <= $signed({dx[16], dx}) + $signed({dy[16], dy});
    end
    if (state == STP_EMIT && px_take && !at_end) begin
      err <= err_nx;
      if (step_x) cur_x <= sx_neg ? cur_x - 16'd1 : cur_x + 16'd1;
      if (step_y) cur_y <= sy_neg ? cur_y - 16'd1 : cur_y + 16'd1;
    end
  end

  assign px       = '{x: cur_x, y: cur_y, color: color};
  assign px_valid = (state == STP_EMIT);  // held until px_take

endmodule

// ==== logic/polyline_ctrl.sv ====
`include "poly_cfg.svh"

module polyline_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  poly_pkg::bus_wr_t bus_wr,
  output logic [9:0]        rd_addr,
  input  logic [15:0]       rd_data,
  output logic              line_start,
  output poly_pkg::vertex_t seg_from,
  output poly_pkg::vertex_t seg_to,
  input  logic              line_done,
  input  logic              lcd_idle,
  output logic [15:0]       color,
  output logic              busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH0,  // first vertex into seg_from
    S_FETCHN,  // next vertex into seg_to
    S_DRAW,    // kick the stepper
    S_WAIT,    // segment in progress
    S_FINISH   // last pixel still on the wire
  } state_t;

  state_t      state;
  logic        reg_hit;
  logic        start;
  logic [15:0] color_q;
  logic [7:0]  count_hi;  // count msb, lsb comes with the start write
  logic [15:0] nverts;    // count frozen at start
  logic [15:0] vidx;      // next vertex to fetch
  logic [1:0]  step;      // 0 addr x, 1 addr y + take x, 2 take y
  logic [15:0] vx;

  // **************************************
  // register file
  // **************************************
  assign reg_hit = bus_wr.valid && (bus_wr.addr[31:16] == `POLY_REG_BASE);
  assign start   = reg_hit && (bus_wr.addr[15:0] == 16'd3) && (state == S_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      color_q  <= '0;
      count_hi <= '0;
    end else if (reg_hit) begin
      case (bus_wr.addr[15:0])
        16'd0:   color_q[15:8] <= bus_wr.data;
        16'd1:   color_q[7:0]  <= bus_wr.data;
        16'd2:   count_hi      <= bus_wr.data;
        default: ;  // count lsb goes straight into nverts
      endcase
    end
  end

  // **************************************
  // vertex walker
  // **************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= S_IDLE;
      step   <= '0;
      vidx   <= '0;
      nverts <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            nverts <= {count_hi, bus_wr.data};  // lsb arrives this cycle
            vidx   <= '0;
            step   <= '0;
            state  <= S_FETCH0;
          end
        end
        S_FETCH0, S_FETCHN: begin
          if (state == S_FETCH0 && step == 2'd0 && nverts < 16'd2) begin
            state <= S_FINISH;  // nothing to draw
          end else if (step == 2'd2) begin
            step  <= '0;
            vidx  <= vidx + 16'd1;
            state <= (state == S_FETCH0) ? S_FETCHN : S_DRAW;
          end else begin
            step <= step + 2'd1;
          end
        end
        S_DRAW: state <= S_WAIT;
        S_WAIT: begin
          if (line_done) state <= (vidx == nverts) ? S_FINISH : S_FETCHN;
        end
        S_FINISH: begin
          if (lcd_idle) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // vertex and colour payload
  always_ff @(posedge clk) begin
    if (start) color <= color_q;  // colour held for the whole drawing
    if (state == S_FETCH0 || state == S_FETCHN) begin
      if (step == 2'd1) vx <= rd_data;
      if (step == 2'd2) begin
        if (state == S_FETCH0) seg_from <= '{x: vx, y: rd_data};
        else                   seg_to   <= '{x: vx, y: rd_data};
      end
    end
    if (state == S_WAIT && line_done) seg_from <= seg_to;  // chain segments
  end

  assign rd_addr    = {vidx[8:0], step[0]};  // word 2n = x, 2n+1 = y
  assign line_start = (state == S_DRAW);
  assign busy       = (state != S_IDLE);

endmodule

// ==== logic/vertex_ram.sv ====
`include "poly_cfg.svh"

module vertex_ram (
  input  logic              clk,
  input  logic              arst_n,
  input  poly_pkg::bus_wr_t bus_wr,
  input  logic [9:0]        rd_addr,
  output logic [15:0]       rd_data
);

  logic [15:0] mem [`POLY_RAM_WORDS];
  logic [7:0]  msb_q;   // high byte waits for its partner
  logic        buf_hit;

  assign buf_hit = bus_wr.valid && (bus_wr.addr[31:16] == `POLY_BUF_BASE);

  // even byte address holds the msb
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      msb_q <= '0;
    end else if (buf_hit && !bus_wr.addr[0]) begin
      msb_q <= bus_wr.data;
    end
  end

  // odd address completes the word
  always_ff @(posedge clk) begin
    if (buf_hit && bus_wr.addr[0]) begin
      mem[bus_wr.addr[10:1]] <= {msb_q, bus_wr.data};
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];  // one clk read
  end

endmodule

// ==== logic/spi_write_slave.sv ====
module spi_write_slave (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              csn,
  input  logic              sclk,
  input  logic              mosi,
  output poly_pkg::bus_wr_t bus_wr
);

  typedef enum logic [1:0] {
    PH_CMD,   // first byte of frame
    PH_ADDR,  // 4 address bytes, msb first
    PH_DATA,  // payload bytes
    PH_SKIP   // unknown command, ignore until csn rises
  } phase_t;

  logic [1:0]  csn_sync;
  logic [1:0]  mosi_sync;
  logic [2:0]  sclk_sync;   // extra stage for edge detect
  logic        sclk_rise;
  logic        byte_done;
  logic        data_done;
  logic [7:0]  rx_byte;
  logic [6:0]  shreg;
  logic [2:0]  bit_cnt;
  logic [1:0]  addr_cnt;
  logic [31:0] addr;
  phase_t      phase;
  logic        wr_valid;
  logic [31:0] wr_addr;
  logic [7:0]  wr_data;

  // **************************************
  // input synchronisers
  // **************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csn_sync  <= 2'b11;  // deselected
      mosi_sync <= 2'b00;
      sclk_sync <= 3'b000;
    end else begin
      csn_sync  <= {csn_sync[0], csn};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_sync <= {sclk_sync[1:0], sclk};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign rx_byte   = {shreg, mosi_sync[1]};  // byte incl. current bit
  assign byte_done = sclk_rise & (bit_cnt == 3'd7) & ~csn_sync[1];
  assign data_done = byte_done & (phase == PH_DATA);

  // **************************************
  // frame decode
  // **************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= PH_CMD;
      bit_cnt  <= '0;
      addr_cnt <= '0;
      shreg    <= '0;
      addr     <= '0;
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= data_done;  // lands 3 clk after the sclk edge
      if (csn_sync[1]) begin
        phase    <= PH_CMD;   // frame ended, rearm
        bit_cnt  <= '0;
        addr_cnt <= '0;
      end else if (sclk_rise) begin
        shreg   <= rx_byte[6:0];
        bit_cnt <= bit_cnt + 3'd1;  // wraps per byte
        if (bit_cnt == 3'd7) begin
          case (phase)
            PH_CMD:  phase <= (rx_byte == 8'h00) ? PH_ADDR : PH_SKIP;
            PH_ADDR: begin
              addr     <= {addr[23:0], rx_byte};
              addr_cnt <= addr_cnt + 2'd1;
              if (addr_cnt == 2'd3) phase <= PH_DATA;
            end
            PH_DATA: addr <= addr + 32'd1;  // next byte goes one up
            default: ;
          endcase
        end
      end
    end
  end

  // write payload
  always_ff @(posedge clk) begin
    if (data_done) begin
      wr_addr <= addr;
      wr_data <= rx_byte;
    end
  end

  assign bus_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== logic/poly_pkg.sv ====
package poly_pkg;

  // one byte written by the spi host
  typedef struct packed {
    logic        valid;  // one clk strobe
    logic [31:0] addr;   // byte address
    logic [7:0]  data;
  } bus_wr_t;

  // polyline point
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
  } vertex_t;

  // pixel headed for the display
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] color;  // rgb565
  } pixel_t;

  // bresenham engine states
  typedef enum logic [1:0] {
    STP_IDLE,   // waiting for line_start
    STP_SETUP,  // deltas latched, error term next
    STP_EMIT    // pixel on px, waiting for px_take
  } step_state_t;

endpackage

// ==== logic/poly_cfg.svh ====
`ifndef POLY_CFG_SVH
`define POLY_CFG_SVH

// vertex buffer, 16-bit words, x and y per vertex
`define POLY_RAM_WORDS 1024

// upper address halves seen on the spi bus
`define POLY_BUF_BASE 16'h1CDD  // vertex buffer region
`define POLY_REG_BASE 16'h1CDE  // colour and count registers

// st7789 command bytes
`define LCD_CASET 8'h2A  // column window
`define LCD_RASET 8'h2B  // row window
`define LCD_RAMWR 8'h2C  // memory write
`define LCD_SCK_DIV 1    // clk cycles per lcd_sck half period

`endif
